// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_mycpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/cpu_stim.txt
# I <instruction word>   D <byte address> <data word>
# W <pc> <register number> <written value>, in program order
I 3c018000  lui   r1, 0x8000
I 34210010  ori   r1, r1, 0x0010
I 2402ffff  addiu r2, r0, -1
I 24040005  addiu r4, r0, 5
I 0044182a  slt   r3, r2, r4
I 0044282b  sltu  r5, r2, r4
I 00013103  sra   r6, r1, 4
I 00013902  srl   r7, r1, 4
I 000440c0  sll   r8, r4, 3
I 01044823  subu  r9, r8, r4
I 01205027  nor   r10, r9, r0
I 01425826  xor   r11, r10, r2
I 304cf0f0  andi  r12, r2, 0xf0f0
I ac0b0010  sw    r11, 0x10(r0)
I 8c0d0010  lw    r13, 0x10(r0)
I 01ad7021  addu  r14, r13, r13
I 8c0f0014  lw    r15, 0x14(r0)
I 11ce0002  beq   r14, r14, +2
I 24140001  addiu r20, r0, 1
I 24150001  addiu r21, r0, 1
I 15ce0005  bne   r14, r14, +5
I 24100077  addiu r16, r0, 0x77
I 0ff00019  jal   0xbfc00064
I 24140002  addiu r20, r0, 2
I 24150002  addiu r21, r0, 2
I 0bf0001c  j     0xbfc00070
I 24140003  addiu r20, r0, 3
I 24150003  addiu r21, r0, 3
I 03f08821  addu  r17, r31, r16
I 02049022  sub   r18, r16, r4
I 024c9825  or    r19, r18, r12
I 0272b020  add   r22, r19, r18
I 02ccb824  and   r23, r22, r12
D 00000014 12345678
W bfc00000 01 80000000
W bfc00004 01 80000010
W bfc00008 02 ffffffff
W bfc0000c 04 00000005
W bfc00010 03 00000001
W bfc00014 05 00000000
W bfc00018 06 f8000001
W bfc0001c 07 08000001
W bfc00020 08 00000028
W bfc00024 09 00000023
W bfc00028 0a ffffffdc
W bfc0002c 0b 00000023
W bfc00030 0c 0000f0f0
W bfc00038 0d 00000023
W bfc0003c 0e 00000046
W bfc00040 0f 12345678
W bfc00054 10 00000077
W bfc00058 1f bfc00060
W bfc00070 11 bfc000d7
W bfc00074 12 00000072
W bfc00078 13 0000f0f2
W bfc0007c 16 0000f164
W bfc00080 17 0000f060

// File: bench/tb_mycpu.sv
module tb_mycpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] reset_pc  = 32'hbfc00000;
    localparam string       stim_path = "bench/cpu_stim.txt";

    logic        clk;
    logic        resetn;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_pc [$];    // expected writeback trace
    logic [31:0] exp_num [$];
    logic [31:0] exp_data [$];
    int          n_words;
    int          wr_idx;
    int          cycles;
    int          cycle_limit;

    mycpu_top #(.reset_pc(reset_pc)) mycpu_top_i (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic load_stim();
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          n;
        int          want;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;  // zero word decodes as a harmless sll r0
            dmem[i] = '0;
        end
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stim_path);
            $display("Verification failed");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0) begin
                n    = 0;
                want = 0;
                case (line.getc(0))
                    "I": begin
                        n    = $sscanf(line, "I %h", a);
                        want = 1;
                        imem[n_words] = a;
                        n_words++;
                    end
                    "D": begin
                        n    = $sscanf(line, "D %h %h", a, b);
                        want = 2;
                        dmem[a[9:2]] = b;  // byte address in, word index out
                    end
                    "W": begin
                        n    = $sscanf(line, "W %h %h %h", a, b, c);
                        want = 3;
                        exp_pc.push_back(a);
                        exp_num.push_back(b);
                        exp_data.push_back(c);
                    end
                    default: ;  // comments and blank lines
                endcase
                if (n != want) begin
                    $display("could not read all fields of the stimulus line %s", line);
                    $display("Verification failed");
                    $fatal(1);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // sram models, one cycle latency

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[9:2]];  // old word on a write
            if (data_sram_wen == 4'hf) dmem[data_sram_addr[9:2]] = data_sram_wdata;
        end
    end

    ////////////////////////////////////////
    // reset and stimulus

    initial begin
        resetn          = 1'b0;
        inst_sram_rdata <= '0;
        data_sram_rdata <= '0;
        n_words         = 0;
        wr_idx          = 0;
        cycles          = 0;
        load_stim();
        cycle_limit = 20 * n_words + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("inst_sram_addr", reset_pc, inst_sram_addr);  // first fetch
        check_value("debug_wb_rf_wen", 32'h0, {28'h0, debug_wb_rf_wen});
        check_value("data_sram_wen", 32'h0, {28'h0, data_sram_wen});
        resetn = 1'b1;
    end

    // write checker, sampled mid cycle
    always @(negedge clk) begin
        if (resetn) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: only %0d of %0d expected register writes arrived",
                         wr_idx, exp_pc.size());
                $display("Verification failed");
                $fatal(1);
            end
            // instruction port is read only
            check_value("inst_sram_en", 32'h1, {31'h0, inst_sram_en});
            check_value("inst_sram_wen", 32'h0, {28'h0, inst_sram_wen});
            check_value("inst_sram_wdata", 32'h0, inst_sram_wdata);
            if (debug_wb_rf_wen != 4'h0) begin
                if (wr_idx >= exp_pc.size()) begin
                    $display("register write seen after the expected trace ended");
                    $display("Verification failed");
                    $fatal(1);
                end
                check_value("debug_wb_pc", exp_pc[wr_idx], debug_wb_pc);
                check_value("debug_wb_rf_wnum", exp_num[wr_idx], {27'h0, debug_wb_rf_wnum});
                check_value("debug_wb_rf_wdata", exp_data[wr_idx], debug_wb_rf_wdata);
                wr_idx++;
                if (wr_idx == exp_pc.size()) begin
                    $display("Verification passed");
                    $finish;
                end
            end
        end
    end

endmodule

// File: compile.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_unit.sv
source/register_file.sv
source/alu.sv
source/hazard_unit.sv
source/mycpu_top.sv
bench/tb_mycpu.sv

// File: source/alu.sv
module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::word_t   y,
    output logic             zero
);
    import cpu_pkg::*;

    logic [4:0] sa;     // shift amount
    logic       lt_s;
    logic       lt_u;

    assign sa   = a[4:0];
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (alu_op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_nor:  y = ~(a | b);
            alu_slt:  y = {31'd0, lt_s};
            alu_sltu: y = {31'd0, lt_u};
            alu_sll:  y = b << sa;
            alu_srl:  y = b >> sa;
            alu_sra:  y = word_t'($signed(b) >>> sa);  // sign fills from the left
            alu_lui:  y = {b[15:0], 16'h0000};
            default:  y = '0;
        endcase
    end

    // branches compare with alu_sub
    assign zero = (y == '0);

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;      // data, address or instruction
    typedef logic [4:0]  reg_addr_t;  // register number

    ////////////////////////////////////////
    // decoded instructions

    typedef enum logic [4:0] {
        op_nop,
        op_add, op_addu, op_sub, op_subu,
        op_and, op_or, op_xor, op_nor,
        op_slt, op_sltu,
        op_sll, op_srl, op_sra,
        op_addiu, op_andi, op_ori, op_lui,
        op_lw, op_sw,
        op_beq, op_bne, op_j, op_jal
    } op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra,
        alu_lui
    } alu_op_e;

    ////////////////////////////////////////
    // primary opcode field, instr[31:26]

    localparam logic [5:0] opcode_special = 6'h00;
    localparam logic [5:0] opcode_j       = 6'h02;
    localparam logic [5:0] opcode_jal     = 6'h03;
    localparam logic [5:0] opcode_beq     = 6'h04;
    localparam logic [5:0] opcode_bne     = 6'h05;
    localparam logic [5:0] opcode_addiu   = 6'h09;
    localparam logic [5:0] opcode_andi    = 6'h0c;
    localparam logic [5:0] opcode_ori     = 6'h0d;
    localparam logic [5:0] opcode_lui     = 6'h0f;
    localparam logic [5:0] opcode_lw      = 6'h23;
    localparam logic [5:0] opcode_sw      = 6'h2b;

    // funct field of special, instr[5:0]
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_srl  = 6'h02;
    localparam logic [5:0] funct_sra  = 6'h03;
    localparam logic [5:0] funct_add  = 6'h20;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_sub  = 6'h22;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_nor  = 6'h27;
    localparam logic [5:0] funct_slt  = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;

    localparam reg_addr_t link_reg = 5'd31;  // jal destination

endpackage

// File: source/decode_unit.sv
module decode_unit (
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::op_e       op,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t dest,
    output logic               use_imm,
    output logic               imm_zero_ext,
    output logic               use_shamt,
    output logic [4:0]         shamt,
    output cpu_pkg::word_t     imm,
    output logic [25:0]        jump_index
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign shamt      = instr[10:6];
    assign jump_index = instr[25:0];

    always_comb begin
        op           = op_nop;
        alu_op       = alu_add;
        dest         = '0;  // no write unless set below
        use_imm      = 1'b0;
        imm_zero_ext = 1'b0;
        use_shamt    = 1'b0;
        case (opcode)
            opcode_special: begin
                dest = rd;
                case (funct)
                    funct_add:  begin op = op_add;  alu_op = alu_add;  end
                    funct_addu: begin op = op_addu; alu_op = alu_add;  end
                    funct_sub:  begin op = op_sub;  alu_op = alu_sub;  end
                    funct_subu: begin op = op_subu; alu_op = alu_sub;  end
                    funct_and:  begin op = op_and;  alu_op = alu_and;  end
                    funct_or:   begin op = op_or;   alu_op = alu_or;   end
                    funct_xor:  begin op = op_xor;  alu_op = alu_xor;  end
                    funct_nor:  begin op = op_nor;  alu_op = alu_nor;  end
                    funct_slt:  begin op = op_slt;  alu_op = alu_slt;  end
                    funct_sltu: begin op = op_sltu; alu_op = alu_sltu; end
                    funct_sll:  begin op = op_sll;  alu_op = alu_sll;  use_shamt = 1'b1; end
                    funct_srl:  begin op = op_srl;  alu_op = alu_srl;  use_shamt = 1'b1; end
                    funct_sra:  begin op = op_sra;  alu_op = alu_sra;  use_shamt = 1'b1; end
                    default:    dest = '0;  // unsupported funct, stays a nop
                endcase
            end
            opcode_addiu: begin
                op      = op_addiu;
                use_imm = 1'b1;
                dest    = rt;
            end
            opcode_andi: begin
                op           = op_andi;
                alu_op       = alu_and;
                use_imm      = 1'b1;
                imm_zero_ext = 1'b1;
                dest         = rt;
            end
            opcode_ori: begin
                op           = op_ori;
                alu_op       = alu_or;
                use_imm      = 1'b1;
                imm_zero_ext = 1'b1;
                dest         = rt;
            end
            opcode_lui: begin
                op      = op_lui;
                alu_op  = alu_lui;
                use_imm = 1'b1;
                dest    = rt;
            end
            opcode_lw: begin
                op      = op_lw;  // address = rs + offset
                use_imm = 1'b1;
                dest    = rt;
            end
            opcode_sw: begin
                op      = op_sw;
                use_imm = 1'b1;
            end
            opcode_beq: begin
                op     = op_beq;
                alu_op = alu_sub;  // equality via zero flag
            end
            opcode_bne: begin
                op     = op_bne;
                alu_op = alu_sub;
            end
            opcode_j:   op = op_j;
            opcode_jal: begin
                op   = op_jal;
                dest = link_reg;
            end
            default: op = op_nop;
        endcase
    end

    assign imm = imm_zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

// File: source/fetch_stage.sv
module fetch_stage #(
    parameter cpu_pkg::word_t reset_pc = 32'hbfc00000
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t target,
    output cpu_pkg::word_t inst_sram_addr,
    output cpu_pkg::word_t fetch_pc,
    output logic           fetch_valid
);
    import cpu_pkg::*;

    word_t pc;  // address presented this cycle

    // fetch_pc and fetch_valid describe the word coming back from the SRAM,
    // i.e. the instruction sitting in decode
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc          <= reset_pc;
            fetch_pc    <= reset_pc;
            fetch_valid <= 1'b0;
        end else if (redirect) begin
            pc          <= target;
            fetch_valid <= 1'b0;  // word in flight is on the wrong path
        end else if (!stall) begin
            pc          <= pc + 32'd4;
            fetch_pc    <= pc;
            fetch_valid <= 1'b1;
        end
    end

    // stalled: ask again for the word in decode so it comes back next cycle
    assign inst_sram_addr = stall ? fetch_pc : pc;

    pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        pc[1:0] == 2'b00)
        else $error("program counter left word alignment");

endmodule

// File: source/hazard_unit.sv
module hazard_unit (
    input  cpu_pkg::reg_addr_t ex_rs,
    input  cpu_pkg::reg_addr_t ex_rt,
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  logic               ex_is_load,
    input  logic               ex_valid,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               mem_valid,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               wb_valid,
    input  cpu_pkg::reg_addr_t wb_dest,
    output logic [1:0]         fwd_a,
    output logic [1:0]         fwd_b,
    output logic               stall
);
    import cpu_pkg::*;

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // a producer that writes a live register which the consumer reads
    function automatic logic hit(input logic valid, input reg_addr_t dest,
                                 input reg_addr_t src);
        return valid && dest != 5'd0 && dest == src;
    endfunction

    assign mem_hit_a = hit(mem_valid, mem_dest, ex_rs);
    assign mem_hit_b = hit(mem_valid, mem_dest, ex_rt);
    assign wb_hit_a  = hit(wb_valid, wb_dest, ex_rs);
    assign wb_hit_b  = hit(wb_valid, wb_dest, ex_rt);

    // bit 1 selects memory stage, bit 0 writeback, none the register file
    assign fwd_a = {mem_hit_a, wb_hit_a && !mem_hit_a};  // memory stage is younger
    assign fwd_b = {mem_hit_b, wb_hit_b && !mem_hit_b};

    // load data only exists in writeback, so the consumer waits one cycle
    assign stall = ex_is_load &&
                   (hit(ex_valid, ex_dest, id_rs) || hit(ex_valid, ex_dest, id_rt));

endmodule

// File: source/mycpu_top.sv
module mycpu_top #(
    parameter cpu_pkg::word_t reset_pc = 32'hbfc00000
) (
    input  logic               clk,
    input  logic               resetn,
    output logic               inst_sram_en,
    output logic [3:0]         inst_sram_wen,
    output cpu_pkg::word_t     inst_sram_addr,
    output cpu_pkg::word_t     inst_sram_wdata,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // decode
    word_t       fetch_pc, id_imm, id_rs_val, id_rt_val;
    logic        fetch_valid, id_use_imm, id_imm_zero_ext, id_use_shamt;
    op_e         id_op;
    alu_op_e     id_alu_op;
    reg_addr_t   id_rs, id_rt, id_dest;
    logic [4:0]  id_shamt;
    logic [25:0] id_jump_index;
    // execute
    logic        ex_valid, ex_use_imm, ex_use_shamt, ex_is_load, alu_zero;
    op_e         ex_op;
    alu_op_e     ex_alu_op;
    reg_addr_t   ex_rs, ex_rt, ex_dest;
    logic [4:0]  ex_shamt;
    logic [25:0] ex_jump_index;
    word_t       ex_pc, ex_imm, ex_rs_val, ex_rt_val, ex_pc_plus4, ex_result;
    word_t       ex_a_fwd, ex_b_fwd, alu_a, alu_b, alu_y, target;
    logic [1:0]  fwd_a, fwd_b;
    logic        stall, redirect;
    // memory and writeback
    logic        mem_valid, mem_is_load, mem_is_store, wb_valid, wb_is_load, rf_we;
    reg_addr_t   mem_dest, wb_dest;
    word_t       mem_pc, mem_result, mem_store_data, wb_pc, wb_result, wb_data;

    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = '0;

    fetch_stage #(.reset_pc(reset_pc)) fetch_stage_i (
        .clk, .resetn, .stall, .redirect, .target,
        .inst_sram_addr, .fetch_pc, .fetch_valid
    );

    ////////////////////////////////////////
    // decode

    decode_unit decode_unit_i (
        .instr(inst_sram_rdata), .op(id_op), .alu_op(id_alu_op),
        .rs(id_rs), .rt(id_rt), .dest(id_dest), .use_imm(id_use_imm),
        .imm_zero_ext(id_imm_zero_ext), .use_shamt(id_use_shamt),
        .shamt(id_shamt), .imm(id_imm), .jump_index(id_jump_index)
    );

    register_file register_file_i (
        .clk, .resetn, .ra0(id_rs), .ra1(id_rt), .we(rf_we), .wa(wb_dest),
        .wd(wb_data), .rd0(id_rs_val), .rd1(id_rt_val)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) ex_valid <= 1'b0;
        else ex_valid <= fetch_valid && !stall && !redirect;  // bubble or squash
    end

    always_ff @(posedge clk) begin
        ex_pc         <= fetch_pc;
        ex_op         <= id_op;
        ex_alu_op     <= id_alu_op;
        ex_rs         <= id_rs;
        ex_rt         <= id_rt;
        ex_dest       <= id_dest;
        ex_use_imm    <= id_use_imm;
        ex_use_shamt  <= id_use_shamt;
        ex_shamt      <= id_shamt;
        ex_imm        <= id_imm;
        ex_jump_index <= id_jump_index;
        ex_rs_val     <= id_rs_val;
        ex_rt_val     <= id_rt_val;
    end

    ////////////////////////////////////////
    // execute

    assign ex_is_load = (ex_op == op_lw);

    hazard_unit hazard_unit_i (
        .ex_rs, .ex_rt, .id_rs, .id_rt, .ex_is_load, .ex_valid, .ex_dest,
        .mem_valid, .mem_dest, .wb_valid, .wb_dest, .fwd_a, .fwd_b, .stall
    );

    assign ex_a_fwd = fwd_a[1] ? mem_result : (fwd_a[0] ? wb_data : ex_rs_val);
    assign ex_b_fwd = fwd_b[1] ? mem_result : (fwd_b[0] ? wb_data : ex_rt_val);
    assign alu_a    = ex_use_shamt ? {27'd0, ex_shamt} : ex_a_fwd;
    assign alu_b    = ex_use_imm ? ex_imm : ex_b_fwd;

    alu alu_i (.a(alu_a), .b(alu_b), .alu_op(ex_alu_op), .y(alu_y), .zero(alu_zero));

    assign ex_pc_plus4 = ex_pc + 32'd4;
    assign ex_result   = (ex_op == op_jal) ? ex_pc + 32'd8 : alu_y;  // link address

    assign redirect = ex_valid && ((ex_op == op_beq && alu_zero) ||
                                   (ex_op == op_bne && !alu_zero) ||
                                   ex_op == op_j || ex_op == op_jal);

    always_comb begin
        if (ex_op == op_j || ex_op == op_jal) target = {ex_pc_plus4[31:28], ex_jump_index, 2'b00};
        else target = ex_pc_plus4 + {ex_imm[29:0], 2'b00};
    end

    ////////////////////////////////////////
    // memory

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) mem_valid <= 1'b0;
        else mem_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_dest       <= ex_dest;
        mem_is_load    <= ex_is_load;
        mem_is_store   <= (ex_op == op_sw);
        mem_result     <= ex_result;
        mem_store_data <= ex_b_fwd;
    end

    assign data_sram_en    = mem_valid && (mem_is_load || mem_is_store);
    assign data_sram_wen   = (mem_valid && mem_is_store) ? 4'hf : 4'h0;  // whole words only
    assign data_sram_addr  = {3'b000, mem_result[28:0]};
    assign data_sram_wdata = mem_store_data;

    ////////////////////////////////////////
    // writeback

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) wb_valid <= 1'b0;
        else wb_valid <= mem_valid;
    end

    always_ff @(posedge clk) begin
        wb_pc      <= mem_pc;
        wb_dest    <= mem_dest;
        wb_is_load <= mem_is_load;
        wb_result  <= mem_result;
    end

    assign wb_data = wb_is_load ? data_sram_rdata : wb_result;  // load data lands now
    assign rf_we   = wb_valid && wb_dest != 5'd0;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_data;

    // address and branch offsets must reach execute sign extended
    offset_sign_ext: assert property (@(posedge clk) disable iff (!resetn)
        fetch_valid && (id_op == op_lw || id_op == op_sw ||
                        id_op == op_beq || id_op == op_bne) |-> !id_imm_zero_ext)
        else $error("offset decoded with zero extension");

endmodule

// File: source/register_file.sv
module register_file (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::reg_addr_t ra0,
    input  cpu_pkg::reg_addr_t ra1,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // write-first: a same-cycle write from writeback wins over the array
    function automatic word_t read_port(input reg_addr_t ra);
        word_t value;
        if (ra == 5'd0) value = '0;
        else if (we && wa == ra) value = wd;
        else value = regs[ra];
        return value;
    endfunction

    assign rd0 = read_port(ra0);
    assign rd1 = read_port(ra1);

endmodule
